/* hw/pps_time_pkg.sv */
`default_nettype none

package pps_time_pkg;

    // Bus widths.
    localparam int WB_ADR_BITS = 8;
    localparam int WB_DAT_BITS = 32;
    localparam int WB_SEL_BITS = 4;

    // Field widths.
    localparam int TRIM_BITS = 16;                 // Trim and holdoff width.
    localparam int SEC_BITS  = 32;                 // Seconds count and stamp width.

    // Byte addresses of the register map.
    localparam logic [WB_ADR_BITS-1:0] CTRL_ADDR     = 8'h00;
    localparam logic [WB_ADR_BITS-1:0] TRIM_ADDR     = 8'h08;
    localparam logic [WB_ADR_BITS-1:0] SEC_ADDR      = 8'h0C;
    localparam logic [WB_ADR_BITS-1:0] LASTPPS_ADDR  = 8'h10;
    localparam logic [WB_ADR_BITS-1:0] LLASTPPS_ADDR = 8'h14;

    // CTRL field layout.
    localparam int CTRL_EN_INT_BIT  = 0;
    localparam int CTRL_USE_EXT_BIT = 1;
    localparam int CTRL_HOLDOFF_LSB = 16;
    localparam logic [WB_DAT_BITS-1:0] CTRL_WR_MASK = 32'hffff_0003; // Bits 15..2 stay zero.

    // Reset defaults.
    localparam logic [TRIM_BITS-1:0] TRIM_RESET = 16'd999; // Period is trim plus one.

    // Bus access FSM encoding.
    localparam int FSM_BITS = 2;
    localparam logic [FSM_BITS-1:0] ST_IDLE      = 2'd0;
    localparam logic [FSM_BITS-1:0] ST_WAIT_TASK = 2'd1;
    localparam logic [FSM_BITS-1:0] ST_CAPTURE   = 2'd2;
    localparam logic [FSM_BITS-1:0] ST_ACK       = 2'd3;

endpackage

`default_nettype wire

/* hw/flag_sync.sv */
`timescale 1ns/10ps
`default_nettype none

module flag_sync (
    input  wire  clk_a_i,
    input  wire  clk_b_i,
    input  wire  rst_i,
    input  wire  flag_i,
    output logic flag_o
);

    logic       toggle_a;
    logic [2:0] sync_b;

    // Each flag in domain A flips the level that crosses over.
    always_ff @(posedge clk_a_i) begin
        if (rst_i) begin
            toggle_a <= 1'b0;
        end else if (flag_i) begin
            toggle_a <= ~toggle_a;
        end
    end

    // Two flops settle the level and the third keeps its previous value.
    always_ff @(posedge clk_b_i) begin
        if (rst_i) begin
            sync_b <= 3'b000;
        end else begin
            sync_b <= {sync_b[1:0], toggle_a};
        end
    end

    assign flag_o = sync_b[2] ^ sync_b[1]; // One clk_b_i cycle per toggle.

endmodule

`default_nettype wire

/* hw/pps_time_register_core.sv */
`timescale 1ns/10ps
`default_nettype none

module pps_time_register_core import pps_time_pkg::*; (
    input  wire                      wb_clk_i,
    input  wire                      sys_clk_i,
    input  wire                      wb_rst_i,
    input  wire                      wb_cyc_i,
    input  wire                      wb_stb_i,
    input  wire                      wb_we_i,
    input  wire  [WB_ADR_BITS-1:0]   wb_adr_i,
    input  wire  [WB_DAT_BITS-1:0]   wb_dat_i,
    input  wire  [WB_SEL_BITS-1:0]   wb_sel_i,
    output logic [WB_DAT_BITS-1:0]   wb_dat_o,
    output logic                     wb_ack_o,
    output logic [TRIM_BITS-1:0]     pps_holdoff_o,
    output logic                     en_int_pps_o,
    output logic                     use_ext_pps_o,
    output logic [TRIM_BITS-1:0]     pps_trim_o,
    output logic                     update_pps_trim_o,
    output logic [SEC_BITS-1:0]      update_sec_o,
    output logic                     load_sec_o,
    input  wire  [TRIM_BITS-1:0]     pps_trim_i,
    input  wire  [SEC_BITS-1:0]      cur_sec_i,
    input  wire  [SEC_BITS-1:0]      last_pps_i,
    input  wire  [SEC_BITS-1:0]      llast_pps_i
);

    logic [FSM_BITS-1:0]    state;
    logic [WB_DAT_BITS-1:0] dat_reg;
    logic [WB_DAT_BITS-1:0] ctrl_reg;
    logic                   bus_req;
    logic                   capture_req;
    logic                   update_trim_req;
    logic                   load_sec_req;
    logic                   capture_sys;
    logic                   ack_sys;
    logic                   ack_wb;
    logic [SEC_BITS-1:0]    cur_sec_hold;
    logic [SEC_BITS-1:0]    last_pps_hold;
    logic [SEC_BITS-1:0]    llast_pps_hold;
    logic [TRIM_BITS-1:0]   trim_hold;

    assign bus_req = wb_cyc_i && wb_stb_i;

    // Requests to the system side leave on the idle cycle that accepts the access.
    assign capture_req     = (state == ST_IDLE) && bus_req && !wb_we_i && (wb_adr_i == SEC_ADDR);
    assign update_trim_req = (state == ST_IDLE) && bus_req && wb_we_i && (wb_adr_i == TRIM_ADDR);
    assign load_sec_req    = (state == ST_IDLE) && bus_req && wb_we_i && (wb_adr_i == SEC_ADDR);

    flag_sync u_capture_sync (
        .clk_a_i (wb_clk_i),
        .clk_b_i (sys_clk_i),
        .rst_i   (wb_rst_i),
        .flag_i  (capture_req),
        .flag_o  (capture_sys)
    );

    flag_sync u_trim_sync (
        .clk_a_i (wb_clk_i),
        .clk_b_i (sys_clk_i),
        .rst_i   (wb_rst_i),
        .flag_i  (update_trim_req),
        .flag_o  (update_pps_trim_o)
    );

    flag_sync u_load_sync (
        .clk_a_i (wb_clk_i),
        .clk_b_i (sys_clk_i),
        .rst_i   (wb_rst_i),
        .flag_i  (load_sec_req),
        .flag_o  (load_sec_o)
    );

    flag_sync u_ack_sync (
        .clk_a_i (sys_clk_i),
        .clk_b_i (wb_clk_i),
        .rst_i   (wb_rst_i),
        .flag_i  (ack_sys),
        .flag_o  (ack_wb)
    );

    // The system side snapshots on capture and answers any finished task.
    always_ff @(posedge sys_clk_i) begin
        if (wb_rst_i) begin
            cur_sec_hold   <= '0;
            last_pps_hold  <= '0;
            llast_pps_hold <= '0;
            trim_hold      <= TRIM_RESET;
            ack_sys        <= 1'b0;
        end else begin
            if (capture_sys) begin
                cur_sec_hold   <= cur_sec_i;
                last_pps_hold  <= last_pps_i;
                llast_pps_hold <= llast_pps_i;
                trim_hold      <= pps_trim_i;
            end
            ack_sys <= capture_sys || update_pps_trim_o || load_sec_o;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (capture_req || update_trim_req || load_sec_req) begin
                        state <= ST_WAIT_TASK;
                    end else if (bus_req) begin
                        state <= wb_we_i ? ST_ACK : ST_CAPTURE;
                    end
                end
                ST_WAIT_TASK: begin
                    if (ack_wb) begin
                        state <= wb_we_i ? ST_ACK : ST_CAPTURE;
                    end
                end
                ST_CAPTURE: state <= ST_ACK;
                default:    state <= ST_IDLE; // Ack lasts one cycle.
            endcase
        end
    end

    // CTRL lives entirely in the bus domain.
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            ctrl_reg <= '0;
        end else if ((state == ST_ACK) && wb_we_i && (wb_adr_i == CTRL_ADDR)) begin
            for (int i = 0; i < WB_SEL_BITS; i++) begin
                if (wb_sel_i[i]) begin
                    ctrl_reg[8*i +: 8] <= wb_dat_i[8*i +: 8] & CTRL_WR_MASK[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (state == ST_IDLE) begin
            dat_reg <= wb_dat_i;                   // Held as payload while waiting.
        end else if (state == ST_CAPTURE) begin
            case (wb_adr_i)
                CTRL_ADDR:     dat_reg <= ctrl_reg;
                TRIM_ADDR:     dat_reg <= {{(WB_DAT_BITS-TRIM_BITS){1'b0}}, trim_hold};
                SEC_ADDR:      dat_reg <= cur_sec_hold;
                LASTPPS_ADDR:  dat_reg <= last_pps_hold;
                LLASTPPS_ADDR: dat_reg <= llast_pps_hold;
                default:       dat_reg <= '0;
            endcase
        end
    end

    assign pps_holdoff_o = ctrl_reg[CTRL_HOLDOFF_LSB +: TRIM_BITS];
    assign en_int_pps_o  = ctrl_reg[CTRL_EN_INT_BIT];
    assign use_ext_pps_o = ctrl_reg[CTRL_USE_EXT_BIT];
    assign pps_trim_o    = dat_reg[TRIM_BITS-1:0];
    assign update_sec_o  = dat_reg[SEC_BITS-1:0];

    assign wb_dat_o = dat_reg;
    assign wb_ack_o = (state == ST_ACK) && wb_cyc_i;

endmodule

`default_nettype wire

/* hw/pps_timer.sv */
`timescale 1ns/10ps
`default_nettype none

module pps_timer import pps_time_pkg::*; (
    input  wire                   sys_clk_i,
    input  wire                   wb_rst_i,
    input  wire                   pps_ext_i,
    input  wire  [TRIM_BITS-1:0]  pps_holdoff_i,
    input  wire                   en_int_pps_i,
    input  wire                   use_ext_pps_i,
    input  wire  [TRIM_BITS-1:0]  pps_trim_i,
    input  wire                   update_pps_trim_i,
    input  wire  [SEC_BITS-1:0]   update_sec_i,
    input  wire                   load_sec_i,
    output logic [TRIM_BITS-1:0]  pps_trim_o,
    output logic [SEC_BITS-1:0]   cur_sec_o,
    output logic [SEC_BITS-1:0]   last_pps_o,
    output logic [SEC_BITS-1:0]   llast_pps_o,
    output logic                  pps_o
);

    logic [1:0]           rst_pipe;
    logic                 rst;
    logic [2:0]           ext_pipe;
    logic                 ext_edge;
    logic [SEC_BITS-1:0]  cycle_cnt;
    logic [TRIM_BITS-1:0] int_cnt;
    logic                 int_mark;
    logic                 mark;
    logic [TRIM_BITS-1:0] since_cnt;
    logic                 accept;

    // Bus-domain reset brought into this clock.
    always_ff @(posedge sys_clk_i) begin
        rst_pipe <= {rst_pipe[0], wb_rst_i};
    end

    assign rst = rst_pipe[1];

    always_ff @(posedge sys_clk_i) begin
        if (rst) begin
            ext_pipe <= 3'b000;
        end else begin
            ext_pipe <= {ext_pipe[1:0], pps_ext_i};
        end
    end

    assign ext_edge = ext_pipe[1] && !ext_pipe[2]; // Rising edge of the settled pin.

    always_ff @(posedge sys_clk_i) begin
        if (rst) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    // Down-counter gives one mark every trim plus one cycles.
    always_ff @(posedge sys_clk_i) begin
        if (rst) begin
            int_cnt <= TRIM_RESET;
        end else if (!en_int_pps_i || (int_cnt == '0)) begin
            int_cnt <= pps_trim_o;
        end else begin
            int_cnt <= int_cnt - 1'b1;
        end
    end

    assign int_mark = en_int_pps_i && (int_cnt == '0);
    assign mark     = use_ext_pps_i ? ext_edge : int_mark;

    // since_cnt counts cycles after the last accepted mark and saturates.
    assign accept = mark && (since_cnt >= pps_holdoff_i);

    always_ff @(posedge sys_clk_i) begin
        if (rst) begin
            since_cnt <= '1;                       // The first mark always passes.
        end else if (accept) begin
            since_cnt <= {{(TRIM_BITS-1){1'b0}}, 1'b1};
        end else if (since_cnt != '1) begin
            since_cnt <= since_cnt + 1'b1;
        end
    end

    always_ff @(posedge sys_clk_i) begin
        if (rst) begin
            pps_trim_o <= TRIM_RESET;
        end else if (update_pps_trim_i) begin
            pps_trim_o <= pps_trim_i;
        end
    end

    always_ff @(posedge sys_clk_i) begin
        if (rst) begin
            cur_sec_o   <= '0;
            last_pps_o  <= '0;
            llast_pps_o <= '0;
            pps_o       <= 1'b0;
        end else begin
            if (load_sec_i) begin
                cur_sec_o <= update_sec_i;         // A load wins over a mark.
            end else if (accept) begin
                cur_sec_o <= cur_sec_o + 1'b1;
            end
            if (accept) begin
                llast_pps_o <= last_pps_o;
                last_pps_o  <= cycle_cnt;
            end
            pps_o <= accept;
        end
    end

endmodule

`default_nettype wire

/* hw/pps_time_top.sv */
`timescale 1ns/10ps
`default_nettype none

module pps_time_top import pps_time_pkg::*; (
    input  wire                     wb_clk_i,
    input  wire                     sys_clk_i,
    input  wire                     wb_rst_i,
    input  wire                     wb_cyc_i,
    input  wire                     wb_stb_i,
    input  wire                     wb_we_i,
    input  wire  [WB_ADR_BITS-1:0]  wb_adr_i,
    input  wire  [WB_DAT_BITS-1:0]  wb_dat_i,
    input  wire  [WB_SEL_BITS-1:0]  wb_sel_i,
    output logic [WB_DAT_BITS-1:0]  wb_dat_o,
    output logic                    wb_ack_o,
    input  wire                     pps_ext_i,
    output logic                    pps_o
);

    logic [TRIM_BITS-1:0] pps_holdoff;
    logic                 en_int_pps;
    logic                 use_ext_pps;
    logic [TRIM_BITS-1:0] core_pps_trim;
    logic                 update_pps_trim;
    logic [SEC_BITS-1:0]  update_sec;
    logic                 load_sec;
    logic [TRIM_BITS-1:0] timer_pps_trim;
    logic [SEC_BITS-1:0]  cur_sec;
    logic [SEC_BITS-1:0]  last_pps;
    logic [SEC_BITS-1:0]  llast_pps;

    pps_time_register_core u_core (
        .wb_clk_i          (wb_clk_i),
        .sys_clk_i         (sys_clk_i),
        .wb_rst_i          (wb_rst_i),
        .wb_cyc_i          (wb_cyc_i),
        .wb_stb_i          (wb_stb_i),
        .wb_we_i           (wb_we_i),
        .wb_adr_i          (wb_adr_i),
        .wb_dat_i          (wb_dat_i),
        .wb_sel_i          (wb_sel_i),
        .wb_dat_o          (wb_dat_o),
        .wb_ack_o          (wb_ack_o),
        .pps_holdoff_o     (pps_holdoff),
        .en_int_pps_o      (en_int_pps),
        .use_ext_pps_o     (use_ext_pps),
        .pps_trim_o        (core_pps_trim),
        .update_pps_trim_o (update_pps_trim),
        .update_sec_o      (update_sec),
        .load_sec_o        (load_sec),
        .pps_trim_i        (timer_pps_trim),
        .cur_sec_i         (cur_sec),
        .last_pps_i        (last_pps),
        .llast_pps_i       (llast_pps)
    );

    pps_timer u_timer (
        .sys_clk_i         (sys_clk_i),
        .wb_rst_i          (wb_rst_i),
        .pps_ext_i         (pps_ext_i),
        .pps_holdoff_i     (pps_holdoff),
        .en_int_pps_i      (en_int_pps),
        .use_ext_pps_i     (use_ext_pps),
        .pps_trim_i        (core_pps_trim),
        .update_pps_trim_i (update_pps_trim),
        .update_sec_i      (update_sec),
        .load_sec_i        (load_sec),
        .pps_trim_o        (timer_pps_trim),
        .cur_sec_o         (cur_sec),
        .last_pps_o        (last_pps),
        .llast_pps_o       (llast_pps),
        .pps_o             (pps_o)
    );

endmodule

`default_nettype wire

/* test/tb_clk_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;       // Equal high and low phases.
        end
    end

endmodule

`default_nettype wire

/* test/tb_pps_time.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_pps_time import pps_time_pkg::*; ();

    localparam longint SYS_NS      = 100;
    localparam longint WB_NS       = 70;
    localparam int     BUS_TIMEOUT = 40;          // Bus clock cycles allowed per access.
    localparam int     EXT_ROUNDS  = 3;
    localparam longint INT_CYCLES  = 6 * 84;      // Longest internal PPS wait.
    localparam longint EDGE_CYCLES = 2 * 72 * EXT_ROUNDS + 2 * 3 * 64;
    localparam longint BUS_OPS     = 48;
    localparam longint WATCHDOG_NS = 2 * (SYS_NS * (INT_CYCLES + EDGE_CYCLES + 64)
                                          + WB_NS * BUS_OPS * BUS_TIMEOUT);

    logic                   sys_clk_i;
    logic                   wb_clk_i;
    logic                   wb_rst_i;
    logic                   wb_cyc_i;
    logic                   wb_stb_i;
    logic                   wb_we_i;
    logic [WB_ADR_BITS-1:0] wb_adr_i;
    logic [WB_DAT_BITS-1:0] wb_dat_i;
    logic [WB_SEL_BITS-1:0] wb_sel_i;
    logic [WB_DAT_BITS-1:0] wb_dat_o;
    logic                   wb_ack_o;
    logic                   pps_ext_i;
    logic                   pps_o;

    logic [31:0]            lfsr_state = 32'hd751_0617;
    int                     errors = 0;
    int                     checks = 0;
    int                     pps_pulses = 0;
    logic [31:0]            act_q[$];
    logic [31:0]            exp_q[$];
    int unsigned            tol_q[$];
    string                  msg_q[$];

    tb_clk_gen #(.PERIOD_NS(100)) sys_clk_gen (.clk_o(sys_clk_i));
    tb_clk_gen #(.PERIOD_NS(70))  wb_clk_gen  (.clk_o(wb_clk_i));

    pps_time_top UUT (
        .wb_clk_i  (wb_clk_i),
        .sys_clk_i (sys_clk_i),
        .wb_rst_i  (wb_rst_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_we_i   (wb_we_i),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_sel_i  (wb_sel_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o),
        .pps_ext_i (pps_ext_i),
        .pps_o     (pps_o)
    );

    // Galois LFSR that steps once for every bit taken.
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] val;
        logic        out_bit;
        val = '0;
        for (int i = 0; i < n; i++) begin
            out_bit    = lfsr_state[0];
            lfsr_state = {1'b0, lfsr_state[31:1]} ^ (out_bit ? 32'hd000_0001 : 32'h0);
            val        = {val[30:0], out_bit};
        end
        return val;
    endfunction

    function automatic logic [31:0] merge_ctrl(input logic [31:0] old, input logic [31:0] data,
                                               input logic [3:0] sel);
        logic [31:0] merged;
        merged = old;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                merged[8*b +: 8] = data[8*b +: 8];
            end
        end
        return merged & 32'hffff_0003;             // Bits 15..2 always read as zero.
    endfunction

    function automatic logic [31:0] whole_periods(input longint elapsed_ns,
                                                  input int unsigned period);
        longint period_ns;
        longint marks;
        period_ns = SYS_NS * longint'(period);
        marks     = (2 * elapsed_ns + period_ns) / (2 * period_ns); // Nearest whole period.
        return marks[31:0];
    endfunction

    task automatic post_check(input logic [31:0] actual, input logic [31:0] expected,
                              input int unsigned tol, input string what);
        act_q.push_back(actual);
        exp_q.push_back(expected);
        tol_q.push_back(tol);
        msg_q.push_back(what);
    endtask

    task automatic bus_cycle(input logic we, input logic [WB_ADR_BITS-1:0] adr,
                             input logic [WB_DAT_BITS-1:0] wdat,
                             input logic [WB_SEL_BITS-1:0] sel,
                             output logic [WB_DAT_BITS-1:0] rdat);
        int waited;
        waited = 0;
        rdat   = '0;
        @(posedge wb_clk_i);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        wb_dat_i <= wdat;
        wb_sel_i <= sel;
        @(negedge wb_clk_i);
        while (!wb_ack_o && (waited < BUS_TIMEOUT)) begin
            @(negedge wb_clk_i);
            waited++;
        end
        if (wb_ack_o) begin
            rdat = wb_dat_o;
        end else begin
            errors++;
            $display("Bus access to address 0x%02h got no acknowledge", adr);
        end
        @(posedge wb_clk_i);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
    endtask

    task automatic write_reg(input logic [WB_ADR_BITS-1:0] adr, input logic [31:0] dat,
                             input logic [WB_SEL_BITS-1:0] sel);
        logic [31:0] ignored;
        bus_cycle(1'b1, adr, dat, sel, ignored);
    endtask

    task automatic read_reg(input logic [WB_ADR_BITS-1:0] adr, output logic [31:0] dat);
        bus_cycle(1'b0, adr, 32'h0, 4'hf, dat);
    endtask

    // The pin rises on the last cycle of the gap, so back to back calls space edges exactly.
    task automatic send_edge_after(input int unsigned gap);
        for (int unsigned i = 1; i <= gap; i++) begin
            @(posedge sys_clk_i);
            pps_ext_i <= (i == gap);
        end
    endtask

    // Every sys cycle with pps_o high counts as one pulse.
    always @(negedge sys_clk_i) begin
        if (pps_o) begin
            pps_pulses++;
        end
    end

    always @(negedge wb_clk_i) begin
        logic [31:0] act;
        logic [31:0] exp_val;
        logic [31:0] diff;
        int unsigned tol;
        string       what;
        while (act_q.size() > 0) begin
            act     = act_q.pop_front();
            exp_val = exp_q.pop_front();
            tol     = tol_q.pop_front();
            what    = msg_q.pop_front();
            diff    = (act >= exp_val) ? act - exp_val : exp_val - act;
            checks++;
            assert (diff <= tol) else begin
                errors++;
                $display("Fail at %0d ns: %s read 0x%08h, expected 0x%08h (tolerance %0d)",
                         $time, what, act, exp_val, tol);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with the tests unfinished", WATCHDOG_NS);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        logic [31:0] rdata;
        logic [31:0] wdata;
        logic [3:0]  sel;
        logic [31:0] ctrl_model;
        logic [31:0] sec_model;
        logic [31:0] s0;
        logic [31:0] s1;
        logic [31:0] last;
        logic [31:0] llast;
        time         t0;
        time         t1;
        int unsigned trim_cycles;
        int unsigned wait_periods;
        int unsigned gap_a;
        int unsigned gap_b;
        int unsigned holdoff;
        int          pulses_before;
        wb_rst_i  <= 1'b1;
        wb_cyc_i  <= 1'b0;
        wb_stb_i  <= 1'b0;
        wb_we_i   <= 1'b0;
        wb_adr_i  <= '0;
        wb_dat_i  <= '0;
        wb_sel_i  <= '0;
        pps_ext_i <= 1'b0;
        repeat (4) @(posedge sys_clk_i);
        wb_rst_i <= 1'b0;
        repeat (4) @(posedge sys_clk_i);           // Timer reset synchronizer releases.

        ctrl_model = '0;
        read_reg(CTRL_ADDR, rdata);
        post_check(rdata, ctrl_model, 0, "CTRL after reset");
        for (int k = 0; k < 4; k++) begin
            wdata = next_bits(32);
            sel   = 4'(next_bits(4));
            write_reg(CTRL_ADDR, wdata, sel);
            ctrl_model = merge_ctrl(ctrl_model, wdata, sel);
            read_reg(CTRL_ADDR, rdata);
            post_check(rdata, ctrl_model, 0, "CTRL byte-select write");
        end
        write_reg(CTRL_ADDR, 32'h0, 4'hf);

        read_reg(TRIM_ADDR, rdata);
        post_check(rdata, {16'h0, TRIM_RESET}, 0, "TRIM after reset");
        wdata = {16'h0, 16'(next_bits(16))};
        write_reg(TRIM_ADDR, wdata, 4'hf);
        read_reg(SEC_ADDR, rdata);                 // Refreshes the captured trim.
        read_reg(TRIM_ADDR, rdata);
        post_check(rdata, wdata, 0, "TRIM after write");

        sec_model = next_bits(32);
        write_reg(SEC_ADDR, sec_model, 4'hf);
        read_reg(SEC_ADDR, rdata);
        post_check(rdata, sec_model, 0, "SEC after load");

        trim_cycles = 20 + next_bits(6);
        write_reg(TRIM_ADDR, trim_cycles, 4'hf);
        write_reg(CTRL_ADDR, 32'h0000_0001, 4'hf);
        read_reg(SEC_ADDR, s0);
        t0           = $time;
        wait_periods = 3 + next_bits(2);
        repeat (wait_periods * (trim_cycles + 1)) @(posedge sys_clk_i);
        read_reg(SEC_ADDR, s1);
        t1 = $time;
        post_check(s1 - s0, whole_periods(longint'(t1 - t0), trim_cycles + 1), 1,
                   "Internal PPS seconds advance");
        read_reg(LASTPPS_ADDR, last);
        read_reg(LLASTPPS_ADDR, llast);
        post_check(last - llast, trim_cycles + 1, 0, "Internal PPS stamp spacing");

        write_reg(CTRL_ADDR, 32'h0000_0002, 4'hf);
        sec_model = next_bits(32);
        write_reg(SEC_ADDR, sec_model, 4'hf);
        for (int r = 0; r < EXT_ROUNDS; r++) begin
            gap_a = 8 + next_bits(6);
            gap_b = 8 + next_bits(6);
            pulses_before = pps_pulses;
            send_edge_after(gap_a);
            send_edge_after(gap_b);
            repeat (6) @(posedge sys_clk_i);
            post_check(pps_pulses - pulses_before, 2, 0, "PPS pulses after external edges");
            sec_model = sec_model + 2;
            read_reg(SEC_ADDR, rdata);
            post_check(rdata, sec_model, 0, "SEC after external edges");
            read_reg(LASTPPS_ADDR, last);
            read_reg(LLASTPPS_ADDR, llast);
            post_check(last - llast, gap_b, 0, "External edge stamp spacing");
        end

        holdoff = 24 + next_bits(5);
        write_reg(CTRL_ADDR, (holdoff << 16) | 32'h2, 4'hf);
        sec_model = next_bits(32);
        write_reg(SEC_ADDR, sec_model, 4'hf);
        for (int r = 0; r < 2; r++) begin
            gap_a = (r == 0) ? holdoff / 2 : holdoff - 1; // The middle edge comes too early.
            gap_b = (r == 0) ? holdoff : 2;
            pulses_before = pps_pulses;
            send_edge_after(holdoff + 8);
            send_edge_after(gap_a);
            send_edge_after(gap_b);
            repeat (6) @(posedge sys_clk_i);
            post_check(pps_pulses - pulses_before, 2, 0, "PPS pulses with holdoff");
            sec_model = sec_model + 2;
            read_reg(SEC_ADDR, rdata);
            post_check(rdata, sec_model, 0, "SEC with holdoff");
            read_reg(LASTPPS_ADDR, last);
            read_reg(LLASTPPS_ADDR, llast);
            post_check(last - llast, gap_a + gap_b, 0, "Stamp spacing with holdoff");
        end

        repeat (2) @(negedge wb_clk_i);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
hw/pps_time_pkg.sv
hw/flag_sync.sv
hw/pps_time_register_core.sv
hw/pps_timer.sv
hw/pps_time_top.sv
test/tb_clk_gen.sv
test/tb_pps_time.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       ?= tb_pps_time
FILELIST  ?= src.f
OBJDIR    ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf $(OBJDIR)
